//--- list.f
rtl/dcache_pkg.sv
rtl/dcache_tags.sv
rtl/dcache_data.sv
rtl/dcache_ctrl.sv
rtl/dcache.sv
tests/dcache_sva.sv
tests/dcache_tb.sv

//--- tests/dcache_tb.sv
/* dcache testbench
   random reads and writes over a few tags against a stalling memory, then halt and flush
*/
`timescale 1ns/100ps

module dcache_tb;
   import dcache_pkg::*;

   localparam int NUM_REQ    = 400;
   localparam int MAX_CYCLES = 20000;   // 400 requests at 40 cycles, flush and reset margin

   logic  CLK = 1'b0;
   logic  nRST = 1'b0;
   logic  dmem_ren = 1'b0;
   logic  dmem_wen = 1'b0;
   logic  halt = 1'b0;
   logic  mem_wait = 1'b0;
   word_t dmem_addr = '0;
   word_t dmem_store = '0;
   word_t mem_load = '0;
   logic  dhit, flushed, mem_ren, mem_wen;
   word_t dmem_load, mem_addr, mem_store;

   word_t model_mem [word_t];   // memory behind the cache
   word_t ref_mem [word_t];     // last value written by the processor
   tag_t  mru [SETS][2];        // two most recent tags per set
   int    mru_n [SETS] = '{default: 0};
   word_t req_rng = 32'h8e61;
   word_t wait_rng = 32'h8e61;
   int    wait_left = 0;
   logic  xfer_open = 1'b0;
   int    xfer_count = 0;
   int    cycles = 0;
   int    hits = 0;
   int    value_errs = 0;
   int    timing_errs = 0;

   dcache dut (.*);

   bind dcache dcache_sva sva (
      .CLK(CLK), .nRST(nRST), .dmem_ren(dmem_ren), .dmem_wen(dmem_wen), .halt(halt),
      .mem_ren(mem_ren), .mem_wen(mem_wen), .mem_wait(mem_wait),
      .mem_addr(mem_addr), .mem_store(mem_store), .flushed(flushed)
   );

   function automatic word_t xorshift(input word_t x);
      word_t y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      return y ^ (y << 5);
   endfunction

   // untouched memory, distinct for every address
   function automatic word_t fill_value(input word_t a);
      return (a * 32'h9e3779b1) ^ 32'h5a5a5a5a;
   endfunction

   function automatic word_t ref_value(input word_t a);
      return ref_mem.exists(a) ? ref_mem[a] : fill_value(a);
   endfunction

   function automatic word_t model_value(input word_t a);
      return model_mem.exists(a) ? model_mem[a] : fill_value(a);
   endfunction

   initial
   begin
      forever #4 CLK = ~CLK;
   end

   always @(posedge CLK)
   begin
      cycles++;
      if (cycles >= MAX_CYCLES)
      begin
         $display("run stopped at the limit of %0d cycles before the flush finished", cycles);
         $display("ERRORS FOUND");
         $finish;
      end
   end

   // memory model, 0 to 3 wait cycles per word
   always @(negedge CLK)
   begin
      if (mem_ren || mem_wen)
      begin
         if (!xfer_open)
         begin
            wait_rng = xorshift(wait_rng);
            wait_left = wait_rng[1:0];
            xfer_open = 1'b1;
         end
         mem_wait = (wait_left != 0);
         if (wait_left != 0)
            wait_left--;
         mem_load = model_value(mem_addr);
      end
      else
      begin
         mem_wait = 1'b0;
         mem_load = '0;
      end
   end

   always @(posedge CLK)
   begin
      if (nRST && (mem_ren || mem_wen) && !mem_wait)
      begin
         xfer_open = 1'b0;
         xfer_count++;
         if (mem_wen)
         begin
            if (mem_addr != HIT_COUNT_ADDR)
               assert (mem_store == ref_value(mem_addr))
               else
               begin
                  value_errs++;
                  $display("[FAIL] %0t write to %h carried %h, expected %h", $time,
                           mem_addr, mem_store, ref_value(mem_addr));
               end
            model_mem[mem_addr] = mem_store;
         end
      end
   end

   task automatic run_request(input logic wr, input word_t addr, input word_t data);
      int   cyc;
      int   start;
      int   set_i;
      logic predict_hit;
      tag_t tag;
      tag = addr[WORD_W-1 -: TAG_W];
      set_i = addr[BYTE_OFF_W+1 +: IDX_W];
      predict_hit = (mru_n[set_i] > 0 && mru[set_i][0] == tag) ||
                    (mru_n[set_i] > 1 && mru[set_i][1] == tag);
      dmem_ren = !wr;
      dmem_wen = wr;
      dmem_addr = addr;
      dmem_store = data;
      start = xfer_count;
      cyc = 0;
      do
      begin
         @(posedge CLK);
         cyc++;
      end
      while (!dhit);
      if (!wr)
         assert (dmem_load == ref_value(addr))
         else
         begin
            value_errs++;
            $display("[FAIL] %0t read of %h returned %h, expected %h", $time, addr,
                     dmem_load, ref_value(addr));
         end
      @(negedge CLK);
      if (xfer_count == start)
      begin
         hits++;
         assert (cyc == 1)
         else
         begin
            timing_errs++;
            $display("request to %h hit but took %0d cycles", addr, cyc);
         end
      end
      assert ((xfer_count != start) == !predict_hit)
      else
      begin
         timing_errs++;
         $display("request to %h saw %0d memory transfers, a %s was expected", addr,
                  xfer_count - start, predict_hit ? "hit" : "miss");
      end
      if (wr)
         ref_mem[addr] = data;
      if (!predict_hit || mru[set_i][0] != tag)
      begin
         mru[set_i][1] = mru[set_i][0];
         mru[set_i][0] = tag;
         if (mru_n[set_i] < 2)
            mru_n[set_i]++;
      end
      dmem_ren = 1'b0;
      dmem_wen = 1'b0;
   endtask

   initial
   begin
      word_t r;
      tag_t  tag;
      repeat (16) @(posedge CLK);
      @(negedge CLK);
      nRST = 1'b1;
      repeat (4) @(negedge CLK);   // idle cycles before traffic
      for (int i = 0; i < NUM_REQ; i++)
      begin
         req_rng = xorshift(req_rng);
         r = req_rng;
         tag = tag_t'(32'h10 + r[1:0] % 3);   // three tags per set force evictions
         req_rng = xorshift(req_rng);
         run_request(r[6], {tag, r[4:2], r[5], 2'b00}, req_rng);
      end
      halt = 1'b1;
      while (!flushed)
         @(posedge CLK);
      repeat (8) @(posedge CLK);   // flushed held, memory quiet
      @(negedge CLK);
      foreach (ref_mem[a])
         assert (model_value(a) == ref_mem[a])
         else
         begin
            value_errs++;
            $display("[FAIL] %0t memory at %h holds %h after flush, expected %h", $time, a,
                     model_value(a), ref_mem[a]);
         end
      assert (model_value(HIT_COUNT_ADDR) == hits)
      else
      begin
         value_errs++;
         $display("[FAIL] %0t hit count %0d, expected %0d", $time,
                  model_value(HIT_COUNT_ADDR), hits);
      end
      $display("value errors %0d, timing errors %0d, assertion failures %0d",
               value_errs, timing_errs, dut.sva.fail_count);
      if (value_errs + timing_errs + dut.sva.fail_count == 0)
         $display("NO ERRORS");
      else
         $display("ERRORS FOUND");
      $finish;
   end

endmodule

//--- tests/dcache_sva.sv
/* dcache port checks
   memory handshake and flush rules, bound onto the cache top level
*/
`timescale 1ns/100ps

module dcache_sva (
   input logic              CLK,
   input logic              nRST,
   input logic              dmem_ren,
   input logic              dmem_wen,
   input logic              halt,
   input logic              mem_ren,
   input logic              mem_wen,
   input logic              mem_wait,
   input dcache_pkg::word_t mem_addr,
   input dcache_pkg::word_t mem_store,
   input logic              flushed
);
   int   fail_count = 0;
   logic started;   // first request or halt seen

   always_ff @(posedge CLK, negedge nRST)
   begin
      if (!nRST)
         started <= 1'b0;
      else if (dmem_ren || dmem_wen || halt)
         started <= 1'b1;
   end

   quiet_after_reset: assert property (@(posedge CLK) disable iff (!nRST)
      !started |-> !mem_ren && !mem_wen && !flushed)
   else
   begin
      fail_count++;
      $error("memory request or flushed seen before the first request or halt");
   end

   hold_on_wait: assert property (@(posedge CLK) disable iff (!nRST)
      (mem_ren || mem_wen) && mem_wait |=>
         $stable(mem_ren) && $stable(mem_wen) && $stable(mem_addr) && $stable(mem_store))
   else
   begin
      fail_count++;
      $error("memory request changed while mem_wait was high");
   end

   one_direction: assert property (@(posedge CLK) disable iff (!nRST)
      !(mem_ren && mem_wen))
   else
   begin
      fail_count++;
      $error("mem_ren and mem_wen both high");
   end

   flushed_final: assert property (@(posedge CLK) disable iff (!nRST)
      flushed |=> flushed && !mem_ren && !mem_wen)
   else
   begin
      fail_count++;
      $error("flushed dropped or a memory request followed it");
   end

endmodule

//--- rtl/dcache.sv
/* dcache top level
   two-way write-back data cache: tag store, data store and controller
*/
`timescale 1ns/100ps

module dcache (
   input  logic              CLK,
   input  logic              nRST,
   input  logic              dmem_ren,
   input  logic              dmem_wen,
   input  logic              halt,
   input  dcache_pkg::word_t dmem_addr,
   input  dcache_pkg::word_t dmem_store,
   input  logic              mem_wait,
   input  dcache_pkg::word_t mem_load,
   output logic              dhit,
   output logic              flushed,
   output logic              mem_ren,
   output logic              mem_wen,
   output dcache_pkg::word_t dmem_load,
   output dcache_pkg::word_t mem_addr,
   output dcache_pkg::word_t mem_store
);
   import dcache_pkg::*;

   idx_t  look_idx;
   tag_t  look_tag;
   logic  upd_way;
   logic  fill_en;
   logic  dirty_en;
   logic  touch_en;
   logic  inval_en;
   logic  hit;
   logic  hit_way;
   logic  victim_way;
   logic  victim_valid;
   logic  victim_dirty;
   tag_t  victim_tag;
   idx_t  idx;
   logic  way;
   logic  off;
   logic  wr_en;
   word_t wr_data;
   word_t rd_data;

   dcache_tags u_tags (
      .CLK, .nRST,
      .look_idx, .look_tag, .upd_way,
      .fill_en, .dirty_en, .touch_en, .inval_en,
      .hit, .hit_way, .victim_way, .victim_valid, .victim_dirty, .victim_tag
   );

   dcache_data u_data (
      .CLK,
      .idx, .way, .off, .wr_en, .wr_data,
      .rd_data
   );

   dcache_ctrl u_ctrl (
      .CLK, .nRST,
      .dmem_ren, .dmem_wen, .halt, .dmem_addr, .dmem_store,
      .mem_wait, .mem_load,
      .hit, .hit_way, .victim_way, .victim_valid, .victim_dirty, .victim_tag,
      .rd_data,
      .dhit, .flushed, .dmem_load,
      .mem_ren, .mem_wen, .mem_addr, .mem_store,
      .look_idx, .look_tag, .upd_way,
      .fill_en, .dirty_en, .touch_en, .inval_en,
      .idx, .way, .off, .wr_en, .wr_data
   );

endmodule

//--- rtl/dcache_ctrl.sv
/* dcache controller
   hit handling, victim write-back, block fill, flush walk and hit count
*/
`timescale 1ns/100ps

module dcache_ctrl (
   input  logic              CLK,
   input  logic              nRST,
   input  logic              dmem_ren,
   input  logic              dmem_wen,
   input  logic              halt,
   input  dcache_pkg::word_t dmem_addr,
   input  dcache_pkg::word_t dmem_store,
   input  logic              mem_wait,
   input  dcache_pkg::word_t mem_load,
   input  logic              hit,
   input  logic              hit_way,
   input  logic              victim_way,
   input  logic              victim_valid,
   input  logic              victim_dirty,
   input  dcache_pkg::tag_t  victim_tag,
   input  dcache_pkg::word_t rd_data,
   output logic              dhit,
   output logic              flushed,
   output dcache_pkg::word_t dmem_load,
   output logic              mem_ren,
   output logic              mem_wen,
   output dcache_pkg::word_t mem_addr,
   output dcache_pkg::word_t mem_store,
   output dcache_pkg::idx_t  look_idx,
   output dcache_pkg::tag_t  look_tag,
   output logic              upd_way,
   output logic              fill_en,
   output logic              dirty_en,
   output logic              touch_en,
   output logic              inval_en,
   output dcache_pkg::idx_t  idx,
   output logic              way,
   output logic              off,
   output logic              wr_en,
   output dcache_pkg::word_t wr_data
);
   import dcache_pkg::*;

   localparam logic [BYTE_OFF_W-1:0] NO_BYTE = '0;

   dstate_t state;
   dstate_t next_state;
   logic    sel_way;
   logic    next_sel_way;
   idx_t    fl_idx;
   logic    fl_way;
   logic    fl_last;
   logic    fl_step;
   word_t   hit_cnt;
   logic    cnt_en;
   tag_t    req_tag;
   idx_t    req_idx;
   logic    req_off;

   assign req_tag = dmem_addr[WORD_W-1 -: TAG_W];
   assign req_idx = dmem_addr[BYTE_OFF_W+1 +: IDX_W];
   assign req_off = dmem_addr[BYTE_OFF_W];
   assign fl_last = (fl_idx == idx_t'(SETS-1)) && fl_way;

   always_ff @(posedge CLK, negedge nRST)
   begin
      if (!nRST)
      begin
         state   <= IDLE;
         sel_way <= 1'b0;
         fl_idx  <= '0;
         fl_way  <= 1'b0;
         hit_cnt <= '0;
      end
      else
      begin
         state   <= next_state;
         sel_way <= next_sel_way;
         if (fl_step)
         begin
            {fl_idx, fl_way} <= {fl_idx, fl_way} + 1'b1;   // walk way 0, way 1, next set
         end
         if (cnt_en)
         begin
            hit_cnt <= hit_cnt + 32'd1;
         end
      end
   end

   always_comb
   begin
      next_state   = state;
      next_sel_way = sel_way;
      fl_step      = 1'b0;
      cnt_en       = 1'b0;
      dhit         = 1'b0;
      flushed      = 1'b0;
      dmem_load    = '0;
      mem_ren      = 1'b0;
      mem_wen      = 1'b0;
      mem_addr     = '0;
      mem_store    = '0;
      look_idx     = req_idx;
      look_tag     = req_tag;
      upd_way      = sel_way;
      fill_en      = 1'b0;
      dirty_en     = 1'b0;
      touch_en     = 1'b0;
      inval_en     = 1'b0;
      idx          = req_idx;
      way          = sel_way;
      off          = req_off;
      wr_en        = 1'b0;
      wr_data      = dmem_store;

      case (state)
         IDLE:
         begin
            if (halt)
            begin
               next_state = FLUSH1;
            end
            else if (dmem_ren || dmem_wen)
            begin
               if (hit)
               begin
                  dhit     = 1'b1;
                  cnt_en   = 1'b1;
                  touch_en = 1'b1;
                  upd_way  = hit_way;
                  way      = hit_way;
                  if (dmem_wen)
                  begin
                     wr_en    = 1'b1;
                     dirty_en = 1'b1;
                  end
                  else
                  begin
                     dmem_load = rd_data;
                  end
               end
               else
               begin
                  upd_way      = victim_way;   // victim_dirty now refers to it
                  next_sel_way = victim_way;
                  next_state   = victim_dirty ? WB1 : FILL1;
               end
            end
            else
            begin
               dhit = 1'b1;
            end
         end
         WB1, WB2:
         begin
            off       = (state == WB2);
            mem_wen   = 1'b1;
            mem_addr  = {victim_tag, req_idx, off, NO_BYTE};
            mem_store = rd_data;
            if (!mem_wait)
            begin
               next_state = (state == WB1) ? WB2 : FILL1;
            end
         end
         FILL1:
         begin
            off      = ~req_off;   // other word first
            mem_ren  = 1'b1;
            mem_addr = {req_tag, req_idx, ~req_off, NO_BYTE};
            wr_data  = mem_load;
            wr_en    = !mem_wait;
            if (!mem_wait)
            begin
               next_state = FILL2;
            end
         end
         FILL2:
         begin
            mem_ren  = 1'b1;
            mem_addr = {req_tag, req_idx, req_off, NO_BYTE};
            wr_data  = dmem_wen ? dmem_store : mem_load;   // store merge
            wr_en    = !mem_wait;
            if (!dmem_wen)
            begin
               dmem_load = mem_load;
            end
            if (!mem_wait)
            begin
               dhit       = 1'b1;
               fill_en    = 1'b1;
               touch_en   = 1'b1;
               dirty_en   = dmem_wen;
               next_state = IDLE;
            end
         end
         FLUSH1, FLUSH2:
         begin
            look_idx = fl_idx;
            upd_way  = fl_way;
            idx      = fl_idx;
            way      = fl_way;
            off      = (state == FLUSH2);
            if (victim_dirty)
            begin
               mem_wen   = 1'b1;
               mem_addr  = {victim_tag, fl_idx, off, NO_BYTE};
               mem_store = rd_data;
            end
            if (!victim_dirty)
            begin
               inval_en   = victim_valid;   // clean way, one cycle
               fl_step    = 1'b1;
               next_state = fl_last ? COUNT : FLUSH1;
            end
            else if (!mem_wait && state == FLUSH1)
            begin
               next_state = FLUSH2;
            end
            else if (!mem_wait)
            begin
               inval_en   = 1'b1;
               fl_step    = 1'b1;
               next_state = fl_last ? COUNT : FLUSH1;
            end
         end
         COUNT:
         begin
            mem_wen   = 1'b1;
            mem_addr  = HIT_COUNT_ADDR;
            mem_store = hit_cnt;
            if (!mem_wait)
            begin
               next_state = DONE;
            end
         end
         DONE:
         begin
            dhit    = 1'b1;
            flushed = 1'b1;
         end
         default:
         begin
            next_state = IDLE;
         end
      endcase
   end

endmodule

//--- rtl/dcache_data.sv
/* dcache data store
   one word per (set, way, offset); async read, clocked write
*/
`timescale 1ns/100ps

module dcache_data (
   input  logic              CLK,
   input  dcache_pkg::idx_t  idx,
   input  logic              way,
   input  logic              off,
   input  logic              wr_en,
   input  dcache_pkg::word_t wr_data,
   output dcache_pkg::word_t rd_data
);
   import dcache_pkg::*;

   word_t mem [SETS][WAYS][BLK_WORDS];

   // read and write share the same location
   always_comb
   begin
      rd_data = mem[idx][way][off];
   end

   always_ff @(posedge CLK)
   begin
      if (wr_en)
      begin
         mem[idx][way][off] <= wr_data;
      end
   end

endmodule

//--- rtl/dcache_tags.sv
/* dcache tag store
   tags, valid/dirty bits and per-set LRU, with hit and victim lookup
*/
`timescale 1ns/100ps

module dcache_tags (
   input  logic             CLK,
   input  logic             nRST,
   input  dcache_pkg::idx_t look_idx,
   input  dcache_pkg::tag_t look_tag,
   input  logic             upd_way,
   input  logic             fill_en,
   input  logic             dirty_en,
   input  logic             touch_en,
   input  logic             inval_en,
   output logic             hit,
   output logic             hit_way,
   output logic             victim_way,
   output logic             victim_valid,
   output logic             victim_dirty,
   output dcache_pkg::tag_t victim_tag
);
   import dcache_pkg::*;

   tag_t                       tags [SETS][WAYS];
   logic [SETS-1:0][WAYS-1:0]  valid;
   logic [SETS-1:0][WAYS-1:0]  dirty;
   logic [SETS-1:0]            lru;      // way to evict next
   logic                       match0;
   logic                       match1;

   always_comb
   begin
      match0 = valid[look_idx][0] && (tags[look_idx][0] == look_tag);
      match1 = valid[look_idx][1] && (tags[look_idx][1] == look_tag);
      hit     = match0 | match1;
      hit_way = match1;

      // empty ways go first, way 0 before way 1
      if (!valid[look_idx][0])
      begin
         victim_way = 1'b0;
      end
      else if (!valid[look_idx][1])
      begin
         victim_way = 1'b1;
      end
      else
      begin
         victim_way = lru[look_idx];
      end

      // state of the way the controller points at
      victim_valid = valid[look_idx][upd_way];
      victim_dirty = valid[look_idx][upd_way] & dirty[look_idx][upd_way];
      victim_tag   = tags[look_idx][upd_way];
   end

   always_ff @(posedge CLK, negedge nRST)
   begin
      if (!nRST)
      begin
         valid <= '0;
         dirty <= '0;
         lru   <= '0;
      end
      else
      begin
         if (fill_en)
         begin
            valid[look_idx][upd_way] <= 1'b1;
            dirty[look_idx][upd_way] <= 1'b0;
         end
         if (dirty_en)
         begin
            dirty[look_idx][upd_way] <= 1'b1;   // overrides fill on write miss
         end
         if (inval_en)
         begin
            valid[look_idx][upd_way] <= 1'b0;
            dirty[look_idx][upd_way] <= 1'b0;
         end
         if (touch_en)
         begin
            lru[look_idx] <= ~upd_way;
         end
      end
   end

   always_ff @(posedge CLK)
   begin
      if (fill_en)
      begin
         tags[look_idx][upd_way] <= look_tag;
      end
   end

endmodule

//--- rtl/dcache_pkg.sv
/* dcache package
   geometry, address field types and controller states for the data cache
*/
package dcache_pkg;

   localparam int WORD_W     = 32;
   localparam int SETS       = 8;
   localparam int WAYS       = 2;
   localparam int BLK_WORDS  = 2;
   localparam int BYTE_OFF_W = 2;
   localparam int IDX_W      = $clog2(SETS);
   localparam int TAG_W      = WORD_W - IDX_W - $clog2(BLK_WORDS) - BYTE_OFF_W;

   typedef logic [WORD_W-1:0] word_t;
   typedef logic [TAG_W-1:0]  tag_t;
   typedef logic [IDX_W-1:0]  idx_t;

   // hit count lands here once the flush is over
   localparam word_t HIT_COUNT_ADDR = 32'h3100;

   // address layout, msb first: tag | index | word in block | byte offset

   typedef enum logic [3:0]
   {
      IDLE,
      WB1,     // victim word 0 out
      WB2,     // victim word 1 out
      FILL1,   // other word in
      FILL2,   // requested word in
      FLUSH1,
      FLUSH2,
      COUNT,   // hit count write
      DONE
   } dstate_t;

endpackage
